// File: vlog.f
+incdir+hw
+incdir+sim
hw/ser_pkg.sv
hw/mem_arbiter.sv
hw/varint_writer.sv
hw/nest_stack.sv
hw/ser_control.sv
hw/ser_aggregate.sv
sim/tb_ser_aggregate.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_ser_aggregate -f vlog.f

status=0
./obj_dir/Vtb_ser_aggregate > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log
then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log
then
    echo "Simulation ended early with exit status $status"
    exit 1
fi
echo "Simulation passed"

// File: sim/tb_ser_vectors.svh
// Each row holds the entry {field id, field type, nested}, the source word, the byte count,
// the bytes from the new write point upwards and the write point after the entry
localparam int NUM_ROWS = 21;

localparam vector_t VECTORS [NUM_ROWS] = '{
    // Plain scalar fields
    '{{29'd1, `SER_TYPE_UINT64, 1'b0}, 64'd150, 4'd3,
      96'h08_96_01, 64'h2fd},
    '{{29'd2, `SER_TYPE_BOOL, 1'b0}, 64'd1, 4'd2,
      96'h10_01, 64'h2fb},
    '{{29'd3, `SER_TYPE_ENUM, 1'b0}, 64'd300, 4'd3,
      96'h18_ac_02, 64'h2f8},
    // Two-byte key, ten-byte value
    '{{29'd16, `SER_TYPE_UINT64, 1'b0}, 64'hffff_ffff_ffff_ffff, 4'd12,
      96'h80_01_ff_ff_ff_ff_ff_ff_ff_ff_ff_01, 64'h2ec},
    '{{29'd4, `SER_TYPE_INT32, 1'b0}, 64'h1234_5678_ffff_fffe, 4'd11,
      96'h20_fe_ff_ff_ff_ff_ff_ff_ff_ff_01, 64'h2e1},
    '{{29'd5, `SER_TYPE_UINT32, 1'b0}, 64'hdead_beef_0000_0080, 4'd3,
      96'h28_80_01, 64'h2de},
    // Zigzag
    '{{29'd6, `SER_TYPE_SINT32, 1'b0}, 64'haaaa_5555_ffff_ffff, 4'd2,
      96'h30_01, 64'h2dc},
    '{{29'd7, `SER_TYPE_SINT64, 1'b0}, 64'd1, 4'd2,
      96'h38_02, 64'h2da},
    '{{29'd8, `SER_TYPE_SINT64, 1'b0}, 64'hffff_ffff_ffff_ffc0, 4'd2,
      96'h40_7f, 64'h2d8},
    '{{29'd9, `SER_TYPE_INT64, 1'b0}, 64'd0, 4'd2,
      96'h48_00, 64'h2d6},
    // Open field 10, two inner fields, close
    '{{29'd10, `SER_TYPE_UINT64, 1'b1}, 64'd0, 4'd0,
      96'h0, 64'h2d6},
    '{{29'd1, `SER_TYPE_UINT64, 1'b0}, 64'd5, 4'd2,
      96'h08_05, 64'h2d4},
    '{{29'd2, `SER_TYPE_SINT32, 1'b0}, 64'h0000_0000_0000_0040, 4'd3,
      96'h10_80_01, 64'h2d1},
    '{{29'd0, `SER_TYPE_UINT64, 1'b0}, 64'd0, 4'd2,
      96'h52_05, 64'h2cf},
    '{{29'd1, `SER_TYPE_SINT32, 1'b0}, 64'h0000_0000_7fff_ffff, 4'd6,
      96'h08_fe_ff_ff_ff_0f, 64'h2c9},
    // Field 21 nested inside field 20
    '{{29'd20, `SER_TYPE_UINT64, 1'b1}, 64'd0, 4'd0,
      96'h0, 64'h2c9},
    '{{29'd3, `SER_TYPE_UINT32, 1'b0}, 64'hffff_ffff_0000_0001, 4'd2,
      96'h18_01, 64'h2c7},
    '{{29'd21, `SER_TYPE_UINT64, 1'b1}, 64'd0, 4'd0,
      96'h0, 64'h2c7},
    '{{29'd1, `SER_TYPE_UINT64, 1'b0}, 64'd7, 4'd2,
      96'h08_07, 64'h2c5},
    '{{29'd0, `SER_TYPE_UINT64, 1'b0}, 64'd0, 4'd3,
      96'haa_01_02, 64'h2c2},
    '{{29'd0, `SER_TYPE_UINT64, 1'b0}, 64'd0, 4'd3,
      96'ha2_01_07, 64'h2bf}
};

// File: sim/tb_ser_aggregate.sv
`timescale 1ns/1ns
`include "ser_config.svh"

module tb_ser_aggregate
    import ser_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int CYCLES_PER_ROW = 200;

    typedef struct packed {
        table_entry_t           entry;
        logic [63:0]            word;
        logic [3:0]             count;
        logic [95:0]            bytes;
        logic [`SER_ADDR_W-1:0] write_point;
    } vector_t;

    `include "tb_ser_vectors.svh"

    logic                   clk;
    logic                   reset;
    logic                   en;
    logic                   entry_valid;
    table_entry_t           entry;
    logic [`SER_ADDR_W-1:0] addr;
    mem_rsp_t               mem_rsp;
    mem_req_t               mem_req;
    logic                   ready;
    logic                   done;
    logic [`SER_ADDR_W-1:0] write_point;

    // 1 KiB byte memory model
    logic [7:0]             mem_bytes [0:1023];
    logic                   rd_pending;
    int unsigned            rd_wait;
    logic [`SER_ADDR_W-1:0] rd_addr;
    int                     done_count;

    ser_aggregate DUT (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .entry_valid (entry_valid),
        .entry       (entry),
        .addr        (addr),
        .mem_rsp     (mem_rsp),
        .mem_req     (mem_req),
        .ready       (ready),
        .done        (done),
        .write_point (write_point)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_levels(input logic ready_got, input logic done_got,
                                input logic ready_exp, input logic done_exp,
                                input string what);
        if (ready_got !== ready_exp || done_got !== done_exp)
            stop_run($sformatf("error at %0t ns: %s ready %b done %b, expected %b %b",
                               $time, what, ready_got, done_got, ready_exp, done_exp));
    endtask

    task automatic check_write_point(input logic [`SER_ADDR_W-1:0] got,
                                     input logic [`SER_ADDR_W-1:0] exp,
                                     input string what);
        if (got !== exp)
            stop_run($sformatf("error at %0t ns: %s write_point 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
    endtask

    task automatic check_request_idle(input mem_req_t req);
        if (req.valid !== 1'b0)
            stop_run($sformatf("error at %0t ns: memory request valid while idle", $time));
    endtask

    // Bytes of one entry from the lowest address up
    task automatic check_bytes(input table_entry_t ent, input logic [`SER_ADDR_W-1:0] base,
                               input logic [95:0] expected, input logic [3:0] count);
        logic [7:0] got;
        logic [7:0] want;
        for (int j = 0; j < int'(count); j++)
        begin
            got = mem_bytes[base[9:0] + 10'(j)];
            want = expected[8 * (int'(count) - 1 - j) +: 8];
            if (got !== want)
                stop_run($sformatf(
                    "error at %0t ns: field %0d byte at 0x%0h is 0x%02h, expected 0x%02h",
                    $time, ent.field_id, base + 64'(j), got, want));
        end
    endtask

    task automatic load_source(input logic [`SER_ADDR_W-1:0] src, input logic [63:0] word);
        value_word_u w;
        w.full = word;
        for (int k = 0; k < 4; k++)
        begin
            mem_bytes[src[9:0] + 10'(k)] = w.half.lo[8 * k +: 8];
            mem_bytes[src[9:0] + 10'(k + 4)] = w.half.hi[8 * k +: 8];
        end
    endtask

    function automatic logic [63:0] read_word(input logic [`SER_ADDR_W-1:0] a);
        logic [63:0] w;
        for (int k = 0; k < 8; k++)
            w[8 * k +: 8] = mem_bytes[a[9:0] + 10'(k)];
        return w;
    endfunction

    // Writes land lane by lane; a read is answered 0 to 3 cycles later
    always @(negedge clk)
    begin
        if (!reset && mem_req.valid)
        begin
            if (mem_req.write)
            begin
                for (int i = 0; i < `SER_LANES; i++)
                begin
                    if (mem_req.lane_en[i])
                        mem_bytes[mem_req.addr[9:0] + 10'(i)] = mem_req.data[i];
                end
            end
            else if (!rd_pending)
            begin
                rd_pending = 1'b1;
                rd_addr = mem_req.addr;
                rd_wait = $urandom % 4;
            end
        end
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            #2;
            mem_rsp.valid = 1'b0;
            if (rd_pending)
            begin
                if (rd_wait == 0)
                begin
                    mem_rsp.valid = 1'b1;
                    mem_rsp.data = read_word(rd_addr);
                    rd_pending = 1'b0;
                end
                else
                    rd_wait = rd_wait - 1;
            end
        end
    end

    always @(negedge clk)
    begin
        if (!reset && done === 1'b1)
            done_count = done_count + 1;
    end

    initial
    begin
        repeat (RESET_CYCLES + NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
        stop_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                           RESET_CYCLES + NUM_ROWS * CYCLES_PER_ROW));
    end

    task automatic apply_row(input int r);
        vector_t                row;
        logic [`SER_ADDR_W-1:0] src;
        row = VECTORS[r];
        src = 64'h100 + 64'(8 * r);
        load_source(src, row.word);
        @(posedge clk);
        #2;
        en = 1'b1;
        entry_valid = 1'b1;
        entry = row.entry;
        addr = src;
        @(posedge clk);
        #2;
        en = 1'b0;
        entry_valid = 1'b0;
        @(negedge clk);
        while (done !== 1'b1)
        begin
            check_levels(ready, done, 1'b0, 1'b0, "while busy");
            @(negedge clk);
        end
        check_levels(ready, done, 1'b0, 1'b1, "done cycle");
        check_write_point(write_point, row.write_point, "after entry");
        check_bytes(row.entry, row.write_point, row.bytes, row.count);
        @(negedge clk);
        check_levels(ready, done, 1'b1, 1'b0, "after done");
    endtask

    initial
    begin
        void'($urandom(32'h7be9));
        for (int a = 0; a < 1024; a++)
            mem_bytes[a] = 8'(a ^ (a >> 5));
        reset = 1'b1;
        en = 1'b0;
        entry_valid = 1'b0;
        entry = '0;
        addr = '0;
        mem_rsp = '0;
        rd_pending = 1'b0;
        rd_wait = 0;
        rd_addr = '0;
        done_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_levels(ready, done, 1'b1, 1'b0, "after reset");
        check_request_idle(mem_req);
        check_write_point(write_point, `SER_BUF_TOP, "after reset");

        for (int r = 0; r < NUM_ROWS; r++)
            apply_row(r);

        // Later entries must leave earlier output untouched
        for (int r = 0; r < NUM_ROWS; r++)
            check_bytes(VECTORS[r].entry, VECTORS[r].write_point, VECTORS[r].bytes,
                        VECTORS[r].count);

        // Catch any stray done pulse
        repeat (2) @(negedge clk);
        if (done_count != NUM_ROWS)
            stop_run($sformatf("error at %0t ns: %0d done pulses for %0d entries",
                               $time, done_count, NUM_ROWS));
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: hw/ser_aggregate.sv
`timescale 1ns/1ns
`include "ser_config.svh"

module ser_aggregate
    import ser_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  logic                   entry_valid,
    input  table_entry_t           entry,
    input  logic [`SER_ADDR_W-1:0] addr,
    input  mem_rsp_t               mem_rsp,
    output mem_req_t               mem_req,
    output logic                   ready,
    output logic                   done,
    output logic [`SER_ADDR_W-1:0] write_point
);

    mem_req_t                   read_req;
    mem_req_t                   value_req;
    mem_req_t                   key_req;
    logic                       read_grant;
    logic                       value_grant;
    logic                       key_grant;
    write_cmd_t                 value_cmd;
    write_cmd_t                 key_cmd;
    logic                       value_written;
    logic                       key_written;
    logic                       push;
    logic                       pop;
    logic [`SER_FIELD_ID_W-1:0] top_field_id;
    logic [`SER_ADDR_W-1:0]     top_write_point;
    logic                       stack_nonempty;

    ser_control control (
        .clk             (clk),
        .reset           (reset),
        .en              (en),
        .entry_valid     (entry_valid),
        .entry           (entry),
        .addr            (addr),
        .mem_rsp         (mem_rsp),
        .read_grant      (read_grant),
        .read_req        (read_req),
        .value_cmd       (value_cmd),
        .key_cmd         (key_cmd),
        .value_written   (value_written),
        .key_written     (key_written),
        .push            (push),
        .pop             (pop),
        .top_field_id    (top_field_id),
        .top_write_point (top_write_point),
        .stack_nonempty  (stack_nonempty),
        .ready           (ready),
        .done            (done),
        .write_point     (write_point)
    );

    // Push happens in the accept cycle, so the id comes straight from the entry port
    nest_stack stack (
        .clk              (clk),
        .reset            (reset),
        .push             (push),
        .pop              (pop),
        .push_field_id    (entry.field_id),
        .push_write_point (write_point),
        .top_field_id     (top_field_id),
        .top_write_point  (top_write_point),
        .nonempty         (stack_nonempty)
    );

    varint_writer value_writer (
        .clk     (clk),
        .reset   (reset),
        .cmd     (value_cmd),
        .grant   (value_grant),
        .req     (value_req),
        .written (value_written)
    );

    varint_writer key_writer (
        .clk     (clk),
        .reset   (reset),
        .cmd     (key_cmd),
        .grant   (key_grant),
        .req     (key_req),
        .written (key_written)
    );

    mem_arbiter arbiter (
        .read_req    (read_req),
        .value_req   (value_req),
        .key_req     (key_req),
        .read_grant  (read_grant),
        .value_grant (value_grant),
        .key_grant   (key_grant),
        .mem_req     (mem_req)
    );

endmodule

// File: hw/ser_control.sv
`timescale 1ns/1ns
`include "ser_config.svh"

module ser_control
    import ser_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       en,
    input  logic                       entry_valid,
    input  table_entry_t               entry,
    input  logic [`SER_ADDR_W-1:0]     addr,
    input  mem_rsp_t                   mem_rsp,
    input  logic                       read_grant,
    output mem_req_t                   read_req,
    output write_cmd_t                 value_cmd,
    output write_cmd_t                 key_cmd,
    input  logic                       value_written,
    input  logic                       key_written,
    output logic                       push,
    output logic                       pop,
    input  logic [`SER_FIELD_ID_W-1:0] top_field_id,
    input  logic [`SER_ADDR_W-1:0]     top_write_point,
    input  logic                       stack_nonempty,
    output logic                       ready,
    output logic                       done,
    output logic [`SER_ADDR_W-1:0]     write_point
);

    typedef enum logic [1:0] {IDLE, LOAD, WRITE, FINISH} state_t;

    state_t                 state;
    table_entry_t           entry_q;
    logic [`SER_ADDR_W-1:0] addr_q;
    logic                   rd_valid;
    logic                   value_seen;
    logic                   key_seen;
    logic                   accept;
    logic                   open_entry;
    logic                   close_entry;
    logic                   issue;
    value_word_u            word;
    logic [63:0]            decoded;
    logic [63:0]            issue_value;
    logic [63:0]            issue_key;
    logic [3:0]             value_len;
    logic [3:0]             key_len;

    assign accept = (state == IDLE) && en && entry_valid;
    assign open_entry = entry.nested;
    assign close_entry = !entry.nested && (entry.field_id == '0);

    assign push = accept && open_entry;
    assign pop = accept && close_entry;
    assign ready = (state == IDLE);
    assign done = (state == FINISH);

    always_comb
    begin
        read_req = '0;
        read_req.valid = rd_valid;
        read_req.addr = addr_q;
        read_req.lane_en = `SER_LANES'(8'hFF);
    end

    always_comb
    begin
        word.full = mem_rsp.data;
        case (entry_q.field_type)
            `SER_TYPE_INT32:
                decoded = {{32{word.half.lo[31]}}, word.half.lo};
            `SER_TYPE_UINT32:
                decoded = {32'd0, word.half.lo};
            `SER_TYPE_SINT32:
                decoded = {32'd0, {word.half.lo[30:0], 1'b0} ^ {32{word.half.lo[31]}}};
            `SER_TYPE_SINT64:
                decoded = {word.full[62:0], 1'b0} ^ {64{word.full[63]}};
            default:
                decoded = word.full;
        endcase

        issue = 1'b0;
        issue_value = decoded;
        issue_key = {32'd0, entry_q.field_id, `SER_WIRE_VARINT};
        if (accept && close_entry)
        begin
            // Bytes written since the matching open
            issue = 1'b1;
            issue_value = top_write_point - write_point;
            issue_key = {32'd0, top_field_id, `SER_WIRE_LEN};
        end
        else if (state == LOAD && mem_rsp.valid)
            issue = 1'b1;

        value_len = varint_length(issue_value);
        key_len = varint_length(issue_key);
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            entry_q <= entry;
            addr_q <= addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            write_point <= `SER_BUF_TOP;
            rd_valid <= 1'b0;
            value_cmd <= '0;
            key_cmd <= '0;
            value_seen <= 1'b0;
            key_seen <= 1'b0;
        end
        else
        begin
            value_cmd.start <= issue;
            key_cmd.start <= issue;
            if (read_grant)
                rd_valid <= 1'b0;

            if (issue)
            begin
                // Value ends just below write_point, key just below the value
                value_cmd.value <= issue_value;
                value_cmd.end_addr <= write_point - `SER_ADDR_W'(1);
                key_cmd.value <= issue_key;
                key_cmd.end_addr <= write_point - `SER_ADDR_W'(1) - `SER_ADDR_W'(value_len);
                write_point <= write_point - `SER_ADDR_W'(value_len) - `SER_ADDR_W'(key_len);
                value_seen <= 1'b0;
                key_seen <= 1'b0;
            end

            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        if (open_entry)
                            state <= FINISH;
                        else if (close_entry)
                            state <= WRITE;
                        else
                        begin
                            state <= LOAD;
                            rd_valid <= 1'b1;
                        end
                    end
                end
                LOAD:
                begin
                    if (mem_rsp.valid)
                        state <= WRITE;
                end
                WRITE:
                begin
                    if (value_written)
                        value_seen <= 1'b1;
                    if (key_written)
                        key_seen <= 1'b1;
                    // Writers may finish in either order
                    if ((value_seen || value_written) && (key_seen || key_written))
                        state <= FINISH;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    a_close_needs_open: assert property (
        @(posedge clk) disable iff (reset)
        (accept && close_entry) |-> stack_nonempty
    );

    a_written_only_in_write: assert property (
        @(posedge clk) disable iff (reset)
        (value_written || key_written) |-> (state == WRITE)
    );

endmodule

// File: hw/nest_stack.sv
`timescale 1ns/1ns
`include "ser_config.svh"

module nest_stack (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  logic [`SER_FIELD_ID_W-1:0] push_field_id,
    input  logic [`SER_ADDR_W-1:0]     push_write_point,
    output logic [`SER_FIELD_ID_W-1:0] top_field_id,
    output logic [`SER_ADDR_W-1:0]     top_write_point,
    output logic                       nonempty
);

    localparam int PTR_W = $clog2(`SER_STACK_ROWS);

    logic [`SER_FIELD_ID_W-1:0] id_mem [`SER_STACK_ROWS];
    logic [`SER_ADDR_W-1:0]     wp_mem [`SER_STACK_ROWS];
    logic [PTR_W:0]             count;
    logic [PTR_W-1:0]           top_idx;

    assign top_idx = count[PTR_W-1:0] - PTR_W'(1);
    assign top_field_id = id_mem[top_idx];
    assign top_write_point = wp_mem[top_idx];
    assign nonempty = (count != '0);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            id_mem[count[PTR_W-1:0]] <= push_field_id;
            wp_mem[count[PTR_W-1:0]] <= push_write_point;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (push)
            count <= count + 1'b1;
        else if (pop && nonempty)
            count <= count - 1'b1;
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> (count != (PTR_W + 1)'(`SER_STACK_ROWS))
    );

endmodule

// File: hw/varint_writer.sv
`timescale 1ns/1ns
`include "ser_config.svh"

module varint_writer
    import ser_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  write_cmd_t cmd,
    input  logic       grant,
    output mem_req_t   req,
    output logic       written
);

    logic [69:0] padded;
    logic [3:0]  len;
    mem_req_t    next_req;

    always_comb
    begin
        padded = {6'd0, cmd.value};
        len = varint_length(cmd.value);
        next_req = '0;
        next_req.valid = 1'b1;
        next_req.write = 1'b1;
        // Last byte sits at end_addr, lowest group at the base
        next_req.addr = cmd.end_addr - `SER_ADDR_W'(len) + `SER_ADDR_W'(1);
        for (int i = 0; i < `SER_LANES; i++)
        begin
            next_req.data[i] = {(i + 1 < int'(len)), padded[7 * i +: 7]};
            next_req.lane_en[i] = (i < int'(len));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req <= '0;
            written <= 1'b0;
        end
        else
        begin
            written <= 1'b0;
            if (req.valid && grant)
            begin
                req.valid <= 1'b0;
                written <= 1'b1;
            end
            if (cmd.start)
                req <= next_req;
        end
    end

    // Controller waits for written before the next start
    a_no_start_while_pending: assert property (
        @(posedge clk) disable iff (reset)
        cmd.start |-> !req.valid
    );

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter
    import ser_pkg::*;
(
    input  mem_req_t read_req,
    input  mem_req_t value_req,
    input  mem_req_t key_req,
    output logic     read_grant,
    output logic     value_grant,
    output logic     key_grant,
    output mem_req_t mem_req
);

    // Read first, then value writer, then key writer
    always_comb
    begin
        read_grant = read_req.valid;
        value_grant = value_req.valid && !read_req.valid;
        key_grant = key_req.valid && !read_req.valid && !value_req.valid;

        if (read_grant)
            mem_req = read_req;
        else if (value_grant)
            mem_req = value_req;
        else
            mem_req = key_req;
    end

endmodule

// File: hw/ser_pkg.sv
`include "ser_config.svh"

package ser_pkg;

    typedef struct packed {
        logic [`SER_FIELD_ID_W-1:0] field_id;
        logic [`SER_TYPE_W-1:0]     field_type;
        logic                       nested;
    } table_entry_t;

    // Lane i goes to addr + i
    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [`SER_ADDR_W-1:0]     addr;
        logic [`SER_LANES-1:0][7:0] data;
        logic [`SER_LANES-1:0]      lane_en;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } value_halves_t;

    typedef union packed {
        logic [63:0]   full;
        value_halves_t half;
    } value_word_u;

    typedef struct packed {
        logic                   start;
        logic [63:0]            value;
        logic [`SER_ADDR_W-1:0] end_addr;
    } write_cmd_t;

    // Number of 7-bit groups the value needs
    function automatic logic [3:0] varint_length(input logic [63:0] value);
        logic [3:0] len;
        len = 4'd1;
        for (int i = 1; i < 10; i++)
        begin
            if ((value >> (7 * i)) != 64'd0)
                len = 4'(i + 1);
        end
        return len;
    endfunction

endpackage

// File: hw/ser_config.svh
`ifndef SER_CONFIG_SVH
`define SER_CONFIG_SVH

`define SER_ADDR_W      64
`define SER_FIELD_ID_W  29
`define SER_TYPE_W      5
`define SER_LANES       10
`define SER_BUF_TOP     64'h300
`define SER_STACK_ROWS  16

// Field type codes
`define SER_TYPE_INT64  5'd3
`define SER_TYPE_UINT64 5'd4
`define SER_TYPE_INT32  5'd5
`define SER_TYPE_BOOL   5'd8
`define SER_TYPE_UINT32 5'd13
`define SER_TYPE_ENUM   5'd14
`define SER_TYPE_SINT32 5'd17
`define SER_TYPE_SINT64 5'd18

// Wire types in the low three key bits
`define SER_WIRE_VARINT 3'd0
`define SER_WIRE_LEN    3'd2

`endif
